//--- hw/mdio_initializer.sv
`timescale 1ns/1ps

module mdio_initializer #(
    parameter net_pkg::phy_addr_t PHY_ADDR = 5'd1,   // target phy on the mdio bus
    parameter int unsigned        MDC_DIV  = 128     // clk125m cycles per mdc period, even
) (
    input  logic                clk125m,
    input  logic                reset_pulse,
    input  logic                restart,             // pcs restart, holds fsm in idle
    output net_pkg::mdio_pins_t mdio,                // mdc and serial data
    output logic                init_done            // whole table written
);

    import net_pkg::*;

    localparam int DIV_W  = $clog2(MDC_DIV);
    localparam int BIT_W  = $clog2(MDIO_FRAME_BITS);
    localparam int IDX_W  = (INIT_WRITES > 1) ? $clog2(INIT_WRITES) : 1;

    localparam logic [DIV_W-1:0] DIV_LAST   = DIV_W'(MDC_DIV - 1);
    localparam logic [DIV_W-1:0] DIV_HALF   = DIV_W'(MDC_DIV / 2 - 1);
    localparam logic [BIT_W-1:0] LAST_BIT   = BIT_W'(MDIO_FRAME_BITS - 1);
    localparam logic [IDX_W-1:0] LAST_ENTRY = IDX_W'(INIT_WRITES - 1);

    typedef enum logic [1:0] {
        ST_IDLE,                                     // wait for restart low
        ST_LOAD,                                     // fill shift reg from table
        ST_SHIFT,                                    // one bit per mdc period
        ST_DONE                                      // last frame out, flag done
    } state_t;

    state_t            state;
    logic [DIV_W-1:0]  div_cnt;                      // mdc phase counter
    logic              rise_tick;                    // mdc goes high next clock
    logic              fall_tick;                    // mdc goes low next clock
    logic              mdc_q;
    logic              mdio_q;
    logic [BIT_W-1:0]  bit_cnt;                      // bits sent of current frame
    logic [IDX_W-1:0]  entry_idx;                    // table entry in flight
    mdio_frame_t       shift_reg;                    // frame being sent, msb first

    // ******************************
    // mdc divider
    // ******************************
    assign rise_tick = (div_cnt == DIV_HALF);
    assign fall_tick = (div_cnt == DIV_LAST);

    always_ff @(posedge clk125m) begin
        if (reset_pulse) begin
            div_cnt <= '0;
            mdc_q   <= 1'b0;
        end else begin
            if (fall_tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (rise_tick) begin
                mdc_q <= 1'b1;                       // second half of period
            end else if (fall_tick) begin
                mdc_q <= 1'b0;
            end
        end
    end

    // ******************************
    // frame sequencer
    // ******************************
    always_ff @(posedge clk125m) begin
        if (reset_pulse || restart) begin
            state     <= ST_IDLE;
            entry_idx <= '0;
            bit_cnt   <= '0;
            mdio_q    <= 1'b1;                       // bus idles high
            init_done <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    entry_idx <= '0;
                    state     <= ST_LOAD;
                end
                ST_LOAD: begin
                    bit_cnt <= '0;
                    state   <= ST_SHIFT;
                end
                ST_SHIFT: begin
                    if (fall_tick) begin
                        mdio_q  <= shift_reg[MDIO_FRAME_BITS-1]; // change while mdc low
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            if (entry_idx == LAST_ENTRY) begin
                                state <= ST_DONE;
                            end else begin
                                entry_idx <= entry_idx + 1'b1;
                                state     <= ST_LOAD;        // next frame back to back
                            end
                        end
                    end
                end
                ST_DONE: begin
                    // last bit sampled by the phy on the rise before this
                    if (fall_tick && !init_done) begin
                        mdio_q    <= 1'b1;
                        init_done <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // payload shifter
    always_ff @(posedge clk125m) begin
        if (state == ST_LOAD) begin
            shift_reg <= mdio_write_frame(PHY_ADDR, INIT_REG[entry_idx], INIT_DATA[entry_idx]);
        end else if (state == ST_SHIFT && fall_tick) begin
            shift_reg <= {shift_reg[MDIO_FRAME_BITS-2:0], 1'b1};
        end
    end

    assign mdio = '{mdc: mdc_q, mdio_out: mdio_q};

endmodule

//--- hw/net_pkg.sv
package net_pkg;

    // ******************************
    // widths with a meaning
    // ******************************
    localparam int MDIO_FRAME_BITS = 64;             // pre + st + op + addr + reg + ta + data
    localparam int INIT_WRITES     = 2;              // entries in the phy init table

    typedef logic [7:0]                 tcp_byte_t;   // one tcp stream byte
    typedef logic [4:0]                 phy_addr_t;   // mdio phy address
    typedef logic [4:0]                 phy_reg_t;    // clause-22 register number
    typedef logic [15:0]                phy_data_t;   // register value
    typedef logic [MDIO_FRAME_BITS-1:0] mdio_frame_t; // whole write frame, msb first

    // ******************************
    // bundles
    // ******************************
    typedef struct packed {
        logic      valid;                            // write strobe
        tcp_byte_t data;                             // payload byte
    } tx_beat_t;

    typedef struct packed {
        logic pll_reset;                             // to the clock pll
        logic pcs_reset;                             // one-shot pcs restart
        logic stack_reset;                           // tcp/ip stack reset
    } net_resets_t;

    typedef struct packed {
        logic mdc;                                   // management clock
        logic mdio_out;                              // serial data toward phy
    } mdio_pins_t;

    // ******************************
    // clause-22 write frame fields
    // ******************************
    localparam logic [31:0] MDIO_PREAMBLE = 32'hFFFF_FFFF; // 32 ones
    localparam logic [1:0]  MDIO_START    = 2'b01;
    localparam logic [1:0]  MDIO_OP_WRITE = 2'b01;
    localparam logic [1:0]  MDIO_TA_WRITE = 2'b10;         // turnaround, driven by master

    // phy init table, entry 0 goes out first
    localparam phy_reg_t  INIT_REG  [INIT_WRITES] = '{5'd0, 5'd4};
    localparam phy_data_t INIT_DATA [INIT_WRITES] = '{16'h1140, 16'h0021}; // an on, 1000fd adv

    function automatic mdio_frame_t mdio_write_frame(input phy_addr_t addr,
                                                     input phy_reg_t  regnum,
                                                     input phy_data_t data);
        return {MDIO_PREAMBLE, MDIO_START, MDIO_OP_WRITE, addr, regnum, MDIO_TA_WRITE, data};
    endfunction

endpackage

//--- hw/network_frontend.sv
`timescale 1ns/1ps

module network_frontend #(
    parameter net_pkg::phy_addr_t PHY_ADDR    = 5'd1, // phy on the management bus
    parameter int unsigned        MDC_DIV     = 128,  // clk125m per mdc, even
    parameter int unsigned        FIFO_DEPTH  = 64,   // pre-buffer bytes
    parameter int unsigned        ALMOST_FULL = 32    // user_full level
) (
    input  logic                 clk125m,
    input  logic                 reset_pulse,         // board reset, sync, active high
    input  logic                 pll_locked,
    input  logic                 pcs_resetdone,       // from the transceiver
    input  net_pkg::tx_beat_t    user_tx,             // user tcp bytes
    input  logic                 stack_full,          // stack tx almost full
    output net_pkg::net_resets_t resets,
    output net_pkg::mdio_pins_t  mdio,                // toward the phy
    output logic                 init_done,           // phy registers written
    output logic                 user_full,
    output net_pkg::tx_beat_t    stack_tx             // bytes into the stack
);

    // ******************************
    // reset sequencing
    // ******************************
    reset_sequencer u_reset_sequencer (
        .clk125m       (clk125m),
        .reset_pulse   (reset_pulse),
        .pll_locked    (pll_locked),
        .pcs_resetdone (pcs_resetdone),
        .resets        (resets)
    );

    // ******************************
    // phy management init
    // ******************************
    mdio_initializer #(
        .PHY_ADDR (PHY_ADDR),
        .MDC_DIV  (MDC_DIV)
    ) u_mdio_initializer (
        .clk125m     (clk125m),
        .reset_pulse (reset_pulse),
        .restart     (resets.pcs_reset),              // rerun table after each pcs restart
        .mdio        (mdio),
        .init_done   (init_done)
    );

    // ******************************
    // tcp tx pre-buffer
    // ******************************
    tx_prefifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .ALMOST_FULL (ALMOST_FULL)
    ) u_tx_prefifo (
        .clk125m     (clk125m),
        .reset_pulse (reset_pulse),
        .user_tx     (user_tx),
        .stack_full  (stack_full),
        .user_full   (user_full),
        .stack_tx    (stack_tx)
    );

endmodule

//--- hw/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
    input  logic                 clk125m,
    input  logic                 reset_pulse,        // system reset, sync, active high
    input  logic                 pll_locked,         // clock pll lock
    input  logic                 pcs_resetdone,      // transceiver reset done, async
    output net_pkg::net_resets_t resets              // pll, pcs and stack resets
);

    // ******************************
    // resetdone synchronizer
    // ******************************
    logic [1:0] resetdone_sync;                      // two flop sync chain
    logic       resetdone_dly;                       // one more stage for edge detect
    logic       resetdone_rise;                      // registered rising edge

    // ******************************
    // one-shot pcs restart
    // ******************************
    logic       restart_enable;                      // sticky, set by first edge
    logic [4:0] enable_shift;                        // enable delay line
    logic       pcs_reset_q;                         // 4 cycle restart pulse

    logic       pll_reset_q;                         // reset_pulse one cycle late
    logic       stack_reset_q;                       // lock loss one cycle late

    // sync chain carries data only
    always_ff @(posedge clk125m) begin
        resetdone_sync <= {resetdone_sync[0], pcs_resetdone};
        resetdone_dly  <= resetdone_sync[1];
    end

    always_ff @(posedge clk125m) begin
        if (reset_pulse) begin
            resetdone_rise <= 1'b0;
        end else begin
            resetdone_rise <= resetdone_sync[1] & ~resetdone_dly; // low to high
        end
    end

    // first edge arms the pulse, later edges are ignored until reset
    always_ff @(posedge clk125m) begin
        if (reset_pulse) begin
            restart_enable <= 1'b0;
        end else if (resetdone_rise) begin
            restart_enable <= 1'b1;
        end
    end

    always_ff @(posedge clk125m) begin
        if (reset_pulse) begin
            enable_shift <= '0;
            pcs_reset_q  <= 1'b0;
        end else begin
            enable_shift <= {enable_shift[3:0], restart_enable};
            pcs_reset_q  <= enable_shift[0] & ~enable_shift[4]; // high for 4 clocks
        end
    end

    // ******************************
    // pll and stack resets
    // ******************************
    always_ff @(posedge clk125m) begin
        pll_reset_q <= reset_pulse;                  // stays high one clock past reset
    end

    always_ff @(posedge clk125m) begin
        stack_reset_q <= ~pll_locked;                // hold stack while clock unstable
    end

    assign resets = '{
        pll_reset:   pll_reset_q,
        pcs_reset:   pcs_reset_q,
        stack_reset: stack_reset_q
    };

endmodule

//--- hw/tx_prefifo.sv
`timescale 1ns/1ps

module tx_prefifo #(
    parameter int unsigned FIFO_DEPTH  = 64,         // bytes of storage
    parameter int unsigned ALMOST_FULL = 32          // user_full threshold
) (
    input  logic              clk125m,
    input  logic              reset_pulse,
    input  net_pkg::tx_beat_t user_tx,               // user write stream
    input  logic              stack_full,            // stack almost full
    output logic              user_full,             // back-pressure to user
    output net_pkg::tx_beat_t stack_tx               // write stream to stack
);

    import net_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);
    localparam logic [CNT_W-1:0] CNT_AF   = CNT_W'(ALMOST_FULL);

    // ******************************
    // storage and pointers
    // ******************************
    tcp_byte_t        mem [FIFO_DEPTH];              // byte ring
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                         // bytes held
    logic             push;
    logic             pop;

    logic             out_valid;                     // beat toward stack
    tcp_byte_t        out_data;

    assign push = user_tx.valid && (count != CNT_FULL); // overflow beats dropped
    assign pop  = (count != '0) && !stack_full;         // drain while stack has room

    always_ff @(posedge clk125m) begin
        if (push) begin
            mem[wr_ptr] <= user_tx.data;
        end
    end

    always_ff @(posedge clk125m) begin
        if (reset_pulse) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // occupancy, push and pop may coincide
    always_ff @(posedge clk125m) begin
        if (reset_pulse) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign user_full = (count >= CNT_AF);

    // ******************************
    // output register
    // ******************************
    always_ff @(posedge clk125m) begin
        if (reset_pulse) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;                        // one clock after the pop
        end
    end

    always_ff @(posedge clk125m) begin
        if (pop) begin
            out_data <= mem[rd_ptr];                 // head byte
        end
    end

    assign stack_tx = '{valid: out_valid, data: out_data};

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the network_frontend testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_network_frontend
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"V$TOP" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    echo "testbench reported a failure"
    exit 1
fi

echo "simulation finished without failures"
exit 0

//--- test/tb_network_frontend.sv
`timescale 1ns/1ps

module tb_network_frontend;

    import net_pkg::*;

    localparam int          MDC_DIV_TB   = 8;        // short mdc period for sim
    localparam logic [4:0]  PHY_ADDR_TB  = 5'd1;
    localparam int          STREAM_BYTES = 300;
    localparam int          AF_LEVEL     = 32;       // default almost-full level

    logic        clk125m;
    logic        reset_pulse;
    logic        pll_locked;
    logic        pcs_resetdone;
    tx_beat_t    user_tx;
    logic        stack_full;
    net_resets_t resets;
    mdio_pins_t  mdio;
    logic        init_done;
    logic        user_full;
    tx_beat_t    stack_tx;

    integer       seed;
    int           error_count = 0;
    int           test_count  = 0;
    bit           past_valid  = 1'b0;               // $past history usable
    tcp_byte_t    ref_q [$];                         // bytes expected on stack_tx
    int           beats_seen  = 0;
    logic [127:0] mdio_hist   = '0;                  // last 128 bits seen on mdc rise
    logic [127:0] frames_expected;
    int           mdc_rises   = 0;                   // rises since restart or reset
    int           init_checks = 0;                   // init_done rises since restart
    logic         mdc_prev    = 1'b0;
    logic         done_prev   = 1'b0;

    network_frontend #(
        .MDC_DIV (MDC_DIV_TB)
    ) u_dut (
        .clk125m       (clk125m),
        .reset_pulse   (reset_pulse),
        .pll_locked    (pll_locked),
        .pcs_resetdone (pcs_resetdone),
        .user_tx       (user_tx),
        .stack_full    (stack_full),
        .resets        (resets),
        .mdio          (mdio),
        .init_done     (init_done),
        .user_full     (user_full),
        .stack_tx      (stack_tx)
    );

    initial begin
        clk125m = 1'b0;
        forever #4 clk125m = ~clk125m;               // 125 MHz
    end

    // clause-22 write frame sent msb first
    function automatic logic [63:0] expected_frame(input logic [4:0] regnum,
                                                   input logic [15:0] value);
        return {32'hFFFF_FFFF, 2'b01, 2'b01, PHY_ADDR_TB, regnum, 2'b10, value};
    endfunction

    assign frames_expected = {expected_frame(5'd0, 16'h1140), expected_frame(5'd4, 16'h0021)};

    task automatic raise_error(input string msg);
        error_count++;
        $display("ERROR @ %0d ns: %s", $time, msg);
    endtask

    task automatic note_timeout(input string what);
        error_count++;
        $display("timeout: gave up waiting for %s", what);
    endtask

    task automatic close_test(input string name, input int errs_before);
        test_count++;
        $display("test %-14s finished, %0d error(s)", name, error_count - errs_before);
    endtask

    // ******************************
    // concurrent checks
    // ******************************
    always @(posedge clk125m) past_valid <= 1'b1;

    pll_reset_follows: assert property (@(posedge clk125m)
        past_valid |-> resets.pll_reset == $past(reset_pulse))
        else raise_error("pll_reset is not reset_pulse one cycle late");

    stack_reset_follows: assert property (@(posedge clk125m)
        past_valid |-> resets.stack_reset == !$past(pll_locked))
        else raise_error("stack_reset is not inverted pll_locked one cycle late");

    no_beat_when_held: assert property (@(posedge clk125m)
        (!reset_pulse && stack_full && $past(stack_full)) |-> !stack_tx.valid)
        else raise_error("stack_tx beat while stack_full held high");

    // stack side scoreboard
    always @(posedge clk125m) begin
        if (stack_tx.valid) begin
            beats_seen++;
            assert (ref_q.size() > 0) else raise_error("stack_tx beat with nothing outstanding");
            if (ref_q.size() > 0) begin
                assert (stack_tx.data == ref_q[0])
                else raise_error($sformatf("stack_tx byte %02h, expected %02h",
                                           stack_tx.data, ref_q[0]));
                void'(ref_q.pop_front());
            end
        end
    end

    // ******************************
    // mdio frame decoder
    // ******************************
    always @(posedge clk125m) begin
        if (reset_pulse || resets.pcs_reset) begin
            mdc_rises   <= 0;
            init_checks <= 0;
        end else if (mdio.mdc && !mdc_prev) begin
            mdc_rises <= mdc_rises + 1;
            mdio_hist <= {mdio_hist[126:0], mdio.mdio_out}; // phy samples here
        end
        mdc_prev  <= mdio.mdc;
        done_prev <= init_done;
        if (init_done && !done_prev) begin
            init_checks <= init_checks + 1;
            assert (mdc_rises >= 128)
            else raise_error($sformatf("init_done after only %0d mdc rises", mdc_rises));
            assert (mdio_hist == frames_expected)
            else raise_error($sformatf("mdio frames %032h, expected %032h",
                                       mdio_hist, frames_expected));
        end
    end

    task automatic wait_ref_empty(input string what);
        int cycles;
        cycles = 0;
        while (ref_q.size() > 0 && cycles < 2000) begin
            @(negedge clk125m);
            cycles++;
        end
        if (ref_q.size() > 0) note_timeout(what);
        for (cycles = 0; cycles < 4; cycles++) begin
            @(negedge clk125m);                      // room for a stray beat
        end
    endtask

    task automatic toggle_pll_lock();
        int errs_before;
        int i;
        errs_before = error_count;
        for (i = 0; i < 200; i++) begin
            @(negedge clk125m);
            if (($random(seed) & 7) == 0) pll_locked = ~pll_locked; // lock drops at random
        end
        @(negedge clk125m);
        pll_locked = 1'b1;
        close_test("resets", errs_before);
    endtask

    task automatic pulse_resetdone();
        int errs_before;
        int cycles;
        int width;
        int i;
        errs_before = error_count;
        @(negedge clk125m);
        pcs_resetdone = 1'b1;
        cycles = 0;
        while (!resets.pcs_reset && cycles < 50) begin
            @(negedge clk125m);
            cycles++;
        end
        if (!resets.pcs_reset) begin
            note_timeout("pcs_reset to rise after resetdone");
        end else begin
            assert (cycles == 6)
            else raise_error($sformatf("pcs_reset rose after %0d cycles, expected 6", cycles));
            width = 0;
            while (resets.pcs_reset && width < 50) begin
                @(negedge clk125m);
                width++;
            end
            if (resets.pcs_reset) begin
                note_timeout("pcs_reset to fall");
            end else begin
                assert (width == 4)
                else raise_error($sformatf("pcs_reset high %0d cycles, expected 4", width));
            end
        end
        // second edge must stay silent
        @(negedge clk125m);
        pcs_resetdone = 1'b0;
        for (i = 0; i < 5; i++) @(negedge clk125m);
        pcs_resetdone = 1'b1;
        for (i = 0; i < 30; i++) begin
            @(negedge clk125m);
            assert (!resets.pcs_reset) else raise_error("pcs_reset pulsed on a later resetdone");
        end
        close_test("pcs restart", errs_before);
    endtask

    task automatic await_phy_init();
        int errs_before;
        int cycles;
        errs_before = error_count;
        cycles = 0;
        while (init_checks == 0 && cycles < 4000) begin
            @(negedge clk125m);
            cycles++;
        end
        if (init_checks == 0) note_timeout("init_done after the pcs restart");
        for (cycles = 0; cycles < 16; cycles++) begin
            @(negedge clk125m);
            assert (init_done) else raise_error("init_done dropped without a restart");
        end
        close_test("mdio init", errs_before);
    endtask

    task automatic stream_random_bytes();
        int       errs_before;
        int       sent;
        int       cycles;
        int       beats_before;
        tx_beat_t beat;
        errs_before  = error_count;
        beats_before = beats_seen;
        sent   = 0;
        cycles = 0;
        while (sent < STREAM_BYTES && cycles < 20000) begin
            @(negedge clk125m);
            cycles++;
            if (($random(seed) & 31) == 0) stack_full = ~stack_full; // bursts of back-pressure
            beat = '0;
            if (!user_full && ($random(seed) & 7) != 0) begin
                beat.valid = 1'b1;
                beat.data  = tcp_byte_t'($random(seed));
                ref_q.push_back(beat.data);
                sent++;
            end
            user_tx = beat;
        end
        if (sent < STREAM_BYTES) note_timeout("room to write the stream");
        @(negedge clk125m);
        user_tx    = '0;
        stack_full = 1'b0;
        wait_ref_empty("the stream to drain");
        assert (beats_seen - beats_before == STREAM_BYTES)
        else raise_error($sformatf("%0d beats on stack_tx, expected %0d",
                                   beats_seen - beats_before, STREAM_BYTES));
        close_test("stream", errs_before);
    endtask

    task automatic fill_to_almost_full();
        int errs_before;
        int i;
        int cycles;
        errs_before = error_count;
        @(negedge clk125m);
        stack_full = 1'b1;
        user_tx    = '0;
        for (i = 0; i < AF_LEVEL; i++) begin
            @(negedge clk125m);
            assert (!user_full) else raise_error($sformatf("user_full high after %0d writes", i));
            user_tx.valid = 1'b1;
            user_tx.data  = tcp_byte_t'($random(seed));
            ref_q.push_back(user_tx.data);
        end
        @(negedge clk125m);
        user_tx = '0;
        assert (user_full) else raise_error("user_full low after 32 writes");
        stack_full = 1'b0;
        cycles = 0;
        while (user_full && cycles < 100) begin
            @(negedge clk125m);
            cycles++;
        end
        if (user_full) note_timeout("user_full to drop after release");
        wait_ref_empty("the almost-full bytes to drain");
        close_test("almost full", errs_before);
    endtask

    // ******************************
    // main sequence
    // ******************************
    initial begin
        seed          = 32'h5055;
        reset_pulse   = 1'b1;
        pll_locked    = 1'b1;
        pcs_resetdone = 1'b0;
        user_tx       = '0;
        stack_full    = 1'b0;
        repeat (8) @(negedge clk125m);               // 8 reset cycles
        reset_pulse = 1'b0;

        toggle_pll_lock();
        pulse_resetdone();
        await_phy_init();
        stream_random_bytes();
        fill_to_almost_full();

        $display("tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/net_pkg.sv
hw/reset_sequencer.sv
hw/mdio_initializer.sv
hw/tx_prefifo.sv
hw/network_frontend.sv
test/tb_network_frontend.sv
